// File: Bender.yml
package:
  name: tyr_system

sources:
  - design/tyr_isa_pkg.sv
  - design/tyr_sys_pkg.sv
  - design/tyr_ram.sv
  - design/tyr_regfile.sv
  - design/tyr_decode.sv
  - design/tyr_exec.sv
  - design/tyr_core.sv
  - design/tyr_system.sv
  - target: test
    files:
      - bench/tyr_system_chk.sv
      - bench/tyr_system_tb.sv

// File: bench/tyr_system_chk.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_system_chk (
    input logic               clk,
    input logic               reset_n,
    input logic               i_run,
    input logic               i_store_valid,
    input logic               i_halt,
    input tyr_sys_pkg::halt_t i_halt_cause
);

    // Core comes out of reset idle
    ast_reset_idle: assert property (@(posedge clk) !reset_n |=> !i_halt && !i_store_valid)
        else $error("halt or store active in the cycle after reset");

    ast_halt_sticky: assert property (@(posedge clk) reset_n && i_halt |=> i_halt)
        else $error("halt dropped without reset");

    // Nothing commits when stopped
    ast_no_store: assert property (
        @(posedge clk) disable iff (!reset_n) (i_halt || !i_run) |-> !i_store_valid)
        else $error("store while halted or paused");

    ast_cause_set: assert property (
        @(posedge clk) disable iff (!reset_n) i_halt |-> i_halt_cause != '0)
        else $error("halt without a cause");

endmodule

`default_nettype wire

// File: bench/tyr_system_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_system_tb;

    import tyr_isa_pkg::*;
    import tyr_sys_pkg::*;

    localparam int    WAIT_LIMIT    = 1000;                    // Cycles per wait loop
    localparam insn_t HALT_INSN     = insn_t'(32'hf000_0000);  // Top nibble 1111
    localparam halt_t CAUSE_ILLEGAL = 2'b10;
    localparam halt_t CAUSE_RSVD    = 2'b01;

    logic       clk;
    logic       reset_n;
    logic       run;
    logic       load;
    imem_addr_t load_addr;
    insn_t      load_insn;
    logic       store_valid;
    store_t     store;
    logic       halt;
    halt_t      halt_cause;

    integer     seed;
    int         errors;
    int         checks;
    insn_t      prog[$];    // Program image, index is the word address
    store_t     exp_q[$];
    store_t     seen_q[$];

    tyr_system i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (run),
        .i_load        (load),
        .i_load_addr   (load_addr),
        .i_load_insn   (load_insn),
        .o_store_valid (store_valid),
        .o_store       (store),
        .o_halt        (halt),
        .o_halt_cause  (halt_cause)
    );

    bind tyr_core tyr_system_chk u_chk (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (i_run),
        .i_store_valid (o_store_valid),
        .i_halt        (o_halt),
        .i_halt_cause  (o_halt_cause)
    );

    always #5 clk = ~clk;

    // Store monitor
    always @(posedge clk) begin
        if (reset_n && store_valid) begin
            seen_q.push_back(store);
        end
    end

    function automatic word_t sext(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic insn_t encode(logic typ, logic [1:0] deref, reg_idx_t z, reg_idx_t x,
                                     reg_idx_t y, op_e op, logic [11:0] imm);
        return {1'b0, typ, deref, z, x, y, op, imm};
    endfunction

    // Result of the op alone, before the addend
    function automatic word_t model_op(op_e op, word_t a, word_t b);
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_ADD:  return a + b;
            OP_MUL:  return a * b;  // Low word is sign-agnostic
            OP_SHL:  return a << b[4:0];
            OP_LE:   return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
            OP_EQ:   return (a == b) ? 32'd1 : 32'd0;
            OP_NOR:  return ~(a | b);
            OP_NAND: return ~(a & b);
            OP_XOR:  return a ^ b;
            OP_SUB:  return a - b;
            OP_XNOR: return ~(a ^ b);
            OP_SHR:  return a >> b[4:0];
            OP_GT:   return ($signed(a) > $signed(b)) ? 32'd1 : 32'd0;
            OP_NE:   return (a != b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    task automatic set_reg(reg_idx_t r, logic [11:0] imm);
        prog.push_back(encode(1'b0, DEREF_REG, r, 4'd0, 4'd0, OP_OR, imm));
    endtask

    // Memory at the immediate gets register z
    task automatic store_reg(reg_idx_t z, logic [11:0] addr);
        prog.push_back(encode(1'b0, DEREF_STORE_RHS, z, 4'd0, 4'd0, OP_OR, addr));
    endtask

    task automatic expect_store(word_t addr, word_t data);
        store_t s;
        s.addr = addr;
        s.data = data;
        exp_q.push_back(s);
    endtask

    // Reset, load the image with run low, then start the core
    task automatic start_run();
        @(negedge clk);
        reset_n = 1'b0;
        run     = 1'b0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        seen_q.delete();
        for (int i = 0; i < prog.size(); i++) begin
            load      = 1'b1;
            load_addr = imem_addr_t'(i);
            load_insn = prog[i];
            @(negedge clk);
        end
        load = 1'b0;
        run  = 1'b1;
    endtask

    task automatic finish_run(string name, halt_t cause, word_t halt_pc);
        int cycles;
        cycles = 0;
        while (!halt && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("ERROR: %s did not halt within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end
        repeat (4) @(negedge clk);  // Room for any store after the halt
        run = 1'b0;
        checks += 3;
        if (halt !== 1'b1) begin
            $display("mismatch o_halt [%s]: got %h expected %h", name, halt, 1'b1);
            errors++;
        end
        if (halt_cause !== cause) begin
            $display("mismatch o_halt_cause [%s]: got %h expected %h", name, halt_cause, cause);
            errors++;
        end
        if (i_dut.u_core.o_pc !== halt_pc) begin
            $display("mismatch o_pc [%s]: got %h expected %h", name, i_dut.u_core.o_pc, halt_pc);
            errors++;
        end
        checks++;
        if (seen_q.size() != exp_q.size()) begin
            $display("mismatch o_store_valid count [%s]: got %h expected %h",
                     name, seen_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < seen_q.size(); i++) begin
            checks += 2;
            if (seen_q[i].addr !== exp_q[i].addr) begin
                $display("mismatch o_store.addr [%s #%0d]: got %h expected %h",
                         name, i, seen_q[i].addr, exp_q[i].addr);
                errors++;
            end
            if (seen_q[i].data !== exp_q[i].data) begin
                $display("mismatch o_store.data [%s #%0d]: got %h expected %h",
                         name, i, seen_q[i].data, exp_q[i].data);
                errors++;
            end
        end
        prog.delete();
        exp_q.delete();
    endtask

    task automatic run_program(string name, halt_t cause, word_t halt_pc);
        start_run();
        finish_run(name, cause, halt_pc);
    endtask

    task automatic alu_reg_ops();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] k;
        op_e         op;
        int          pc_h;
        set_reg(4'd4, 12'h040);  // Store address
        for (int p = 0; p < 3; p++) begin
            a = 12'($random(seed));
            b = 12'($random(seed));
            set_reg(4'd1, a);
            set_reg(4'd2, b);
            for (int i = 0; i < 16; i++) begin
                op = op_e'(i);
                k  = 12'($random(seed));
                if (op != OP_RSVD) begin
                    prog.push_back(encode(1'b0, DEREF_STORE_Z, 4'd4, 4'd1, 4'd2, op, k));
                    expect_store(32'h40, model_op(op, sext(a), sext(b)) + sext(k));
                end
            end
        end
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        run_program("alu_reg", CAUSE_ILLEGAL, pc_h);
    endtask

    task automatic alu_imm_ops();
        op_e         ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_LE, OP_GT, OP_SHR};
        logic [11:0] imms[6] = '{12'hffb, 12'h123, 12'h800, 12'h7ff, 12'hf00, 12'hfe3};
        int          pc_h;
        set_reg(4'd1, 12'h9c4);
        set_reg(4'd2, 12'h0d7);
        set_reg(4'd4, 12'h050);
        for (int i = 0; i < 6; i++) begin
            prog.push_back(encode(1'b1, DEREF_STORE_Z, 4'd4, 4'd1, 4'd2, ops[i], imms[i]));
            // Immediate is the second operand, Y is added after
            expect_store(32'h50, model_op(ops[i], sext(12'h9c4), sext(imms[i])) + 32'h0d7);
        end
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        run_program("alu_imm", CAUSE_ILLEGAL, pc_h);
    endtask

    task automatic memory_ops();
        int pc_h;
        set_reg(4'd1, 12'h010);
        set_reg(4'd2, 12'h5a5);
        prog.push_back(encode(1'b0, DEREF_STORE_Z, 4'd1, 4'd2, 4'd0, OP_OR, 12'd3));
        expect_store(32'h10, 32'h5a5 + 32'd3);
        prog.push_back(encode(1'b0, DEREF_STORE_RHS, 4'd2, 4'd1, 4'd0, OP_ADD, 12'd1));
        expect_store(32'h11, 32'h5a5);
        prog.push_back(encode(1'b0, DEREF_LOAD, 4'd5, 4'd1, 4'd0, OP_OR, 12'd1));
        prog.push_back(encode(1'b0, DEREF_LOAD, 4'd6, 4'd0, 4'd0, OP_OR, 12'h010));
        store_reg(4'd5, 12'h020);
        expect_store(32'h20, 32'h5a5);
        store_reg(4'd6, 12'h021);
        expect_store(32'h21, 32'h5a8);
        set_reg(4'd0, 12'h077);  // Dropped by r0
        store_reg(4'd0, 12'h022);
        expect_store(32'h22, 32'h0);
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        run_program("memory", CAUSE_ILLEGAL, pc_h);
    endtask

    task automatic jump_over_store();
        int pc_s;
        int pc_h;
        set_reg(4'd1, 12'h007);
        // P reads as its own address plus one, target skips one word
        prog.push_back(encode(1'b0, DEREF_REG, REG_P, REG_P, 4'd0, OP_ADD, 12'd1));
        store_reg(4'd1, 12'h030);
        pc_s = prog.size();
        store_reg(REG_P, 12'h031);
        expect_store(32'h31, pc_s + 1);
        prog.push_back(encode(1'b0, DEREF_STORE_Z, 4'd0, REG_P, 4'd0, OP_OR, 12'd0));
        expect_store(32'h0, pc_s + 2);
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        run_program("jump", CAUSE_ILLEGAL, pc_h);
    endtask

    task automatic halt_causes();
        int pc_h;
        set_reg(4'd1, 12'h011);
        set_reg(4'd4, 12'h070);
        prog.push_back(encode(1'b0, DEREF_STORE_Z, 4'd4, 4'd1, 4'd0, OP_OR, 12'd0));
        expect_store(32'h70, 32'h11);
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        store_reg(4'd1, 12'h071);  // Never reached
        run_program("illegal", CAUSE_ILLEGAL, pc_h);
        set_reg(4'd1, 12'h022);
        store_reg(4'd1, 12'h072);
        expect_store(32'h72, 32'h22);
        pc_h = prog.size();
        prog.push_back(encode(1'b0, DEREF_REG, 4'd3, 4'd1, 4'd1, OP_RSVD, 12'd0));
        store_reg(4'd1, 12'h073);
        prog.push_back(HALT_INSN);
        run_program("reserved", CAUSE_RSVD, pc_h);
    endtask

    task automatic pause_resume();
        int cycles;
        int held;
        int pc_h;
        set_reg(4'd4, 12'h060);
        for (int i = 0; i < 6; i++) begin
            prog.push_back(encode(1'b0, DEREF_STORE_Z, 4'd4, 4'd0, 4'd0, OP_OR, 12'(i * 17 + 1)));
            expect_store(32'h60, i * 17 + 1);
        end
        pc_h = prog.size();
        prog.push_back(HALT_INSN);
        start_run();
        cycles = 0;
        while (seen_q.size() < 2 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (seen_q.size() < 2) begin
            $display("ERROR: pause program produced fewer than two stores within %0d cycles",
                     WAIT_LIMIT);
            errors++;
        end
        run  = 1'b0;
        held = seen_q.size();
        repeat (5) @(negedge clk);
        checks++;
        if (seen_q.size() != held) begin
            $display("mismatch o_store_valid count while paused: got %h expected %h",
                     seen_q.size(), held);
            errors++;
        end
        run = 1'b1;
        finish_run("pause", CAUSE_ILLEGAL, pc_h);
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b0;
        run       = 1'b0;
        load      = 1'b0;
        load_addr = '0;
        load_insn = '0;
        seed      = 32'he546f12b;
        errors    = 0;
        checks    = 0;
        alu_reg_ops();
        alu_imm_ops();
        memory_ops();
        jump_over_store();
        halt_causes();
        pause_resume();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/tyr_core.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_core (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_run,
    input  tyr_isa_pkg::insn_t  i_insn,
    output tyr_isa_pkg::word_t  o_pc,
    output tyr_isa_pkg::word_t  o_load_addr,
    input  tyr_isa_pkg::word_t  i_load_data,
    output logic                o_store_valid,
    output tyr_sys_pkg::store_t o_store,
    output logic                o_halt,
    output tyr_sys_pkg::halt_t  o_halt_cause
);

    import tyr_isa_pkg::*;
    import tyr_sys_pkg::*;

    word_t pc;
    word_t pc_plus1;
    word_t pc_next;
    dec_t  dec;
    logic  reserved;
    word_t x_val;
    word_t y_val;
    word_t z_val;
    word_t rhs;
    logic  halt_q;
    halt_t cause_q;
    logic  active;
    logic  commit;
    logic  reg_wr;
    word_t wr_data;

    assign pc_plus1 = pc + 1'b1;

    assign active = i_run && !halt_q;
    assign commit = active && !dec.illegal;  // A halting insn commits nothing

    // deref 00 and 01 target Z, 10 and 11 target memory
    assign reg_wr  = commit && !dec.deref[1];
    assign wr_data = (dec.deref == DEREF_LOAD) ? i_load_data : rhs;
    assign pc_next = (reg_wr && dec.z == REG_P) ? wr_data : pc_plus1;

    assign o_load_addr   = rhs;
    assign o_store_valid = commit && dec.deref[1];
    assign o_store       = (dec.deref == DEREF_STORE_Z) ?
                           '{addr: z_val, data: rhs} :
                           '{addr: rhs, data: z_val};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= RESET_VECTOR;
        end else if (commit) begin
            pc <= pc_next;
        end
    end

    // Sticky until reset, pc stays on the halting instruction
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            halt_q  <= 1'b0;
            cause_q <= '0;
        end else if (active && dec.illegal) begin
            halt_q              <= 1'b1;
            cause_q.illegal     <= !reserved;
            cause_q.reserved_op <= reserved;
        end
    end

    assign o_pc         = pc;
    assign o_halt       = halt_q;
    assign o_halt_cause = cause_q;

    tyr_decode u_decode (
        .i_insn     (i_insn),
        .o_dec      (dec),
        .o_reserved (reserved)
    );

    tyr_regfile u_regfile (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_x_idx   (dec.x),
        .i_y_idx   (dec.y),
        .i_wr_idx  (dec.z),
        .i_pc_next (pc_plus1),
        .i_wr_en   (reg_wr),
        .i_wr_data (wr_data),
        .o_x       (x_val),
        .o_y       (y_val)
    )
    ;

    // Mirror copy of the registers, gives the Z read for stores
    tyr_regfile u_zbank (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_x_idx   (dec.z),
        .i_y_idx   (dec.z),
        .i_wr_idx  (dec.z),
        .i_pc_next (pc_plus1),
        .i_wr_en   (reg_wr),
        .i_wr_data (wr_data),
        .o_x       (z_val),
        .o_y       ()
    );

    tyr_exec u_exec (
        .i_dec (dec),
        .i_x   (x_val),
        .i_y   (y_val),
        .o_rhs (rhs)
    );

endmodule

`default_nettype wire

// File: design/tyr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_decode (
    input  tyr_isa_pkg::insn_t i_insn,
    output tyr_isa_pkg::dec_t  o_dec,
    output logic               o_reserved
);

    import tyr_isa_pkg::*;

    logic halt_nibble;

    assign halt_nibble = {i_insn.fmt, i_insn.typ, i_insn.deref} == NIBBLE_HALT;

    // Reserved opcode only means something in the ALU format
    assign o_reserved = !i_insn.fmt && i_insn.op == OP_RSVD;

    always_comb begin
        o_dec.z       = i_insn.z;
        o_dec.x       = i_insn.x;
        o_dec.y       = i_insn.y;
        o_dec.op      = i_insn.op;
        o_dec.typ     = i_insn.typ;
        o_dec.deref   = i_insn.deref;
        o_dec.imm     = {{20{i_insn.imm[11]}}, i_insn.imm};
        o_dec.illegal = halt_nibble || o_reserved;

        // Other formats collapse to r0 <- 0, which commits nothing visible
        if (i_insn.fmt) begin
            o_dec.z     = '0;
            o_dec.x     = '0;
            o_dec.y     = '0;
            o_dec.op    = OP_OR;
            o_dec.typ   = 1'b0;
            o_dec.deref = DEREF_REG;
            o_dec.imm   = '0;
        end
    end

endmodule

`default_nettype wire

// File: design/tyr_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_exec (
    input  tyr_isa_pkg::dec_t  i_dec,
    input  tyr_isa_pkg::word_t i_x,
    input  tyr_isa_pkg::word_t i_y,
    output tyr_isa_pkg::word_t o_rhs
);

    import tyr_isa_pkg::*;

    word_t              b_op;    // Second operand of the op
    word_t              addend;  // Added after the op
    word_t              alu;
    logic signed [31:0] a_s;
    logic signed [31:0] b_s;
    logic [4:0]         shamt;

    // Type 1 swaps Y and the immediate
    assign b_op   = i_dec.typ ? i_dec.imm : i_y;
    assign addend = i_dec.typ ? i_y : i_dec.imm;

    assign a_s   = i_x;
    assign b_s   = b_op;
    assign shamt = b_op[4:0];

    always_comb begin
        case (i_dec.op)
            OP_OR:   alu = i_x | b_op;
            OP_AND:  alu = i_x & b_op;
            OP_ADD:  alu = a_s + b_s;
            OP_MUL:  alu = a_s * b_s;      // Low half only
            OP_SHL:  alu = i_x << shamt;
            OP_LE:   alu = word_t'(a_s <= b_s);
            OP_EQ:   alu = word_t'(a_s == b_s);
            OP_NOR:  alu = ~(i_x | b_op);
            OP_NAND: alu = ~(i_x & b_op);
            OP_XOR:  alu = i_x ^ b_op;
            OP_SUB:  alu = a_s - b_s;
            OP_XNOR: alu = i_x ^ ~b_op;
            OP_SHR:  alu = i_x >> shamt;   // Logical
            OP_GT:   alu = word_t'(a_s > b_s);
            OP_NE:   alu = word_t'(a_s != b_s);
            default: alu = '0;             // Reserved op halts the core
        endcase
    end

    assign o_rhs = alu + addend;

endmodule

`default_nettype wire

// File: design/tyr_isa_pkg.sv
`default_nettype none

package tyr_isa_pkg;

    typedef logic [31:0] word_t;   // Data and address word
    typedef logic [3:0]  reg_idx_t;

    localparam reg_idx_t REG_P = 4'd15;  // Program counter

    // Top nibble of an instruction that stops the core
    localparam logic [3:0] NIBBLE_HALT = 4'b1111;

    localparam logic [1:0] DEREF_REG       = 2'b00;  // Z <- rhs
    localparam logic [1:0] DEREF_LOAD      = 2'b01;  // Z <- [rhs]
    localparam logic [1:0] DEREF_STORE_Z   = 2'b10;  // [Z] <- rhs
    localparam logic [1:0] DEREF_STORE_RHS = 2'b11;  // [rhs] <- Z

    typedef enum logic [3:0] {
        OP_OR   = 4'b0000,
        OP_AND  = 4'b0001,
        OP_ADD  = 4'b0010,
        OP_MUL  = 4'b0011,
        OP_RSVD = 4'b0100,
        OP_SHL  = 4'b0101,
        OP_LE   = 4'b0110,
        OP_EQ   = 4'b0111,
        OP_NOR  = 4'b1000,
        OP_NAND = 4'b1001,
        OP_XOR  = 4'b1010,
        OP_SUB  = 4'b1011,
        OP_XNOR = 4'b1100,
        OP_SHR  = 4'b1101,
        OP_GT   = 4'b1110,
        OP_NE   = 4'b1111
    } op_e;

    // Instruction word as laid out in memory, MSB first
    typedef struct packed {
        logic        fmt;    // Zero for the three-operand format
        logic        typ;    // Immediate takes the second-operand slot
        logic [1:0]  deref;
        reg_idx_t    z;
        reg_idx_t    x;
        reg_idx_t    y;
        op_e         op;
        logic [11:0] imm;
    } insn_t;

    typedef struct packed {
        reg_idx_t   z;
        reg_idx_t   x;
        reg_idx_t   y;
        op_e        op;
        logic       typ;
        logic [1:0] deref;
        word_t      imm;      // Already sign-extended
        logic       illegal;  // Either halt cause
    } dec_t;

endpackage

`default_nettype wire

// File: design/tyr_ram.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_ram #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  T                         i_wdata,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output T                         o_rdata
);

    T mem [DEPTH];  // Contents come only from writes

    // Writes are held off while reset is asserted, so a stray strobe
    // during reset leaves the loaded image alone
    always_ff @(posedge clk) begin
        if (reset_n && i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];  // Asynchronous read

endmodule

`default_nettype wire

// File: design/tyr_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_regfile (
    input  logic                 clk,
    input  logic                 reset_n,
    input  tyr_isa_pkg::reg_idx_t i_x_idx,
    input  tyr_isa_pkg::reg_idx_t i_y_idx,
    input  tyr_isa_pkg::reg_idx_t i_wr_idx,
    input  tyr_isa_pkg::word_t    i_pc_next,
    input  logic                 i_wr_en,
    input  tyr_isa_pkg::word_t    i_wr_data,
    output tyr_isa_pkg::word_t    o_x,
    output tyr_isa_pkg::word_t    o_y
);

    import tyr_isa_pkg::*;

    word_t regs [1:14];  // r0 and P are not stored here

    function automatic word_t read_port(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (idx == REG_P) begin
            val = i_pc_next;  // P reads as pc + 1
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        o_x = read_port(i_x_idx);
        o_y = read_port(i_y_idx);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx != REG_P) begin
            regs[i_wr_idx] <= i_wr_data;  // Core owns P
        end
    end

endmodule

`default_nettype wire

// File: design/tyr_sys_pkg.sv
`default_nettype none

package tyr_sys_pkg;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // Memories decode only the low bits of a word address
    typedef logic [IMEM_AW-1:0] imem_addr_t;
    typedef logic [DMEM_AW-1:0] dmem_addr_t;

    localparam tyr_isa_pkg::word_t RESET_VECTOR = '0;

    // One data-memory write
    typedef struct packed {
        tyr_isa_pkg::word_t addr;
        tyr_isa_pkg::word_t data;
    } store_t;

    // Why the core stopped
    typedef struct packed {
        logic illegal;      // Top nibble 1111
        logic reserved_op;  // Opcode 0100
    } halt_t;

endpackage

`default_nettype wire

// File: design/tyr_system.sv
`timescale 1ns/1ns
`default_nettype none

module tyr_system (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    i_run,
    input  logic                    i_load,
    input  tyr_sys_pkg::imem_addr_t i_load_addr,
    input  tyr_isa_pkg::insn_t      i_load_insn,
    output logic                    o_store_valid,
    output tyr_sys_pkg::store_t     o_store,
    output logic                    o_halt,
    output tyr_sys_pkg::halt_t      o_halt_cause
);

    import tyr_isa_pkg::*;
    import tyr_sys_pkg::*;

    insn_t fetch_insn;
    word_t pc;
    word_t load_addr;
    word_t load_data;

    // Store strobe and record go straight out as well as to dmem
    tyr_core u_core (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (i_run),
        .i_insn        (fetch_insn),
        .o_pc          (pc),
        .o_load_addr   (load_addr),
        .i_load_data   (load_data),
        .o_store_valid (o_store_valid),
        .o_store       (o_store),
        .o_halt        (o_halt),
        .o_halt_cause  (o_halt_cause)
    );

    tyr_ram #(.T(insn_t), .DEPTH(IMEM_WORDS)) u_imem (
        .clk     (clk),
        .reset_n (reset_n),
        .i_we    (i_load),
        .i_waddr (i_load_addr),
        .i_wdata (i_load_insn),
        .i_raddr (imem_addr_t'(pc)),
        .o_rdata (fetch_insn)
    );

    tyr_ram #(.T(word_t), .DEPTH(DMEM_WORDS)) u_dmem (
        .clk     (clk),
        .reset_n (reset_n),
        .i_we    (o_store_valid),
        .i_waddr (dmem_addr_t'(o_store.addr)),
        .i_wdata (o_store.data),
        .i_raddr (dmem_addr_t'(load_addr)),
        .o_rdata (load_data)
    );

endmodule

`default_nettype wire

// File: src.f
design/tyr_isa_pkg.sv
design/tyr_sys_pkg.sv
design/tyr_ram.sv
design/tyr_regfile.sv
design/tyr_decode.sv
design/tyr_exec.sv
design/tyr_core.sv
design/tyr_system.sv
bench/tyr_system_chk.sv
bench/tyr_system_tb.sv
